/* hw/des_pkg.sv */
package des_pkg;

    typedef logic [63:0] block_t;
    typedef logic [31:0] half_t;
    typedef logic [55:0] cd_t;
    typedef logic [47:0] subkey_t;
    typedef logic [5:0]  sbox_in_t;
    typedef logic [3:0]  sbox_out_t;
    typedef logic [3:0]  round_idx_t;

    typedef enum logic [1:0] {
        st_idle,
        st_run,
        st_done
    } des_state_t;

    localparam int des_rounds = 16;

    // bit r is set when round r+1 rotates by one place rather than two.
    localparam logic [15:0] shift_sched = 16'b1000_0001_0000_0011;

    // all tables use FIPS 46 numbering, where bit 1 is the most significant bit.
    localparam byte unsigned ip_tab [64] = '{
        58, 50, 42, 34, 26, 18, 10, 2, 60, 52, 44, 36, 28, 20, 12, 4,
        62, 54, 46, 38, 30, 22, 14, 6, 64, 56, 48, 40, 32, 24, 16, 8,
        57, 49, 41, 33, 25, 17,  9, 1, 59, 51, 43, 35, 27, 19, 11, 3,
        61, 53, 45, 37, 29, 21, 13, 5, 63, 55, 47, 39, 31, 23, 15, 7
    };

    localparam byte unsigned fp_tab [64] = '{
        40, 8, 48, 16, 56, 24, 64, 32, 39, 7, 47, 15, 55, 23, 63, 31,
        38, 6, 46, 14, 54, 22, 62, 30, 37, 5, 45, 13, 53, 21, 61, 29,
        36, 4, 44, 12, 52, 20, 60, 28, 35, 3, 43, 11, 51, 19, 59, 27,
        34, 2, 42, 10, 50, 18, 58, 26, 33, 1, 41,  9, 49, 17, 57, 25
    };

    localparam byte unsigned e_tab [48] = '{
        32,  1,  2,  3,  4,  5,  4,  5,  6,  7,  8,  9,
         8,  9, 10, 11, 12, 13, 12, 13, 14, 15, 16, 17,
        16, 17, 18, 19, 20, 21, 20, 21, 22, 23, 24, 25,
        24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32,  1
    };

    localparam byte unsigned p_tab [32] = '{
        16,  7, 20, 21, 29, 12, 28, 17,  1, 15, 23, 26,  5, 18, 31, 10,
         2,  8, 24, 14, 32, 27,  3,  9, 19, 13, 30,  6, 22, 11,  4, 25
    };

    localparam byte unsigned pc1_tab [56] = '{
        57, 49, 41, 33, 25, 17,  9,  1, 58, 50, 42, 34, 26, 18,
        10,  2, 59, 51, 43, 35, 27, 19, 11,  3, 60, 52, 44, 36,
        63, 55, 47, 39, 31, 23, 15,  7, 62, 54, 46, 38, 30, 22,
        14,  6, 61, 53, 45, 37, 29, 21, 13,  5, 28, 20, 12,  4
    };

    localparam byte unsigned pc2_tab [48] = '{
        14, 17, 11, 24,  1,  5,  3, 28, 15,  6, 21, 10,
        23, 19, 12,  4, 26,  8, 16,  7, 27, 20, 13,  2,
        41, 52, 31, 37, 47, 55, 30, 40, 51, 45, 33, 48,
        44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32
    };

    function automatic block_t initial_perm(block_t x);
        block_t r;
        for (int i = 0; i < 64; i++) begin
            r[63 - i] = x[64 - ip_tab[i]];
        end
        return r;
    endfunction

    function automatic block_t final_perm(block_t x);
        block_t r;
        for (int i = 0; i < 64; i++) begin
            r[63 - i] = x[64 - fp_tab[i]];
        end
        return r;
    endfunction

    function automatic subkey_t expand(half_t x);
        subkey_t r;
        for (int i = 0; i < 48; i++) begin
            r[47 - i] = x[32 - e_tab[i]];
        end
        return r;
    endfunction

    function automatic half_t p_perm(half_t x);
        half_t r;
        for (int i = 0; i < 32; i++) begin
            r[31 - i] = x[32 - p_tab[i]];
        end
        return r;
    endfunction

    // parity bits 8, 16, ... 64 are simply not selected.
    function automatic cd_t pc1(block_t x);
        cd_t r;
        for (int i = 0; i < 56; i++) begin
            r[55 - i] = x[64 - pc1_tab[i]];
        end
        return r;
    endfunction

    function automatic subkey_t pc2(cd_t x);
        subkey_t r;
        for (int i = 0; i < 48; i++) begin
            r[47 - i] = x[56 - pc2_tab[i]];
        end
        return r;
    endfunction

endpackage

/* hw/des_sbox.sv */
`timescale 1ns/1ns

module des_sbox (
    input  des_pkg::subkey_t mixed,
    output des_pkg::half_t   sub
);
    import des_pkg::*;

    // each table is stored row by row, sixteen columns per row.
    localparam sbox_out_t sbox_tab [8][64] = '{
        '{
            14,  4, 13,  1,  2, 15, 11,  8,  3, 10,  6, 12,  5,  9,  0,  7,
             0, 15,  7,  4, 14,  2, 13,  1, 10,  6, 12, 11,  9,  5,  3,  8,
             4,  1, 14,  8, 13,  6,  2, 11, 15, 12,  9,  7,  3, 10,  5,  0,
            15, 12,  8,  2,  4,  9,  1,  7,  5, 11,  3, 14, 10,  0,  6, 13
        },
        '{
            15,  1,  8, 14,  6, 11,  3,  4,  9,  7,  2, 13, 12,  0,  5, 10,
             3, 13,  4,  7, 15,  2,  8, 14, 12,  0,  1, 10,  6,  9, 11,  5,
             0, 14,  7, 11, 10,  4, 13,  1,  5,  8, 12,  6,  9,  3,  2, 15,
            13,  8, 10,  1,  3, 15,  4,  2, 11,  6,  7, 12,  0,  5, 14,  9
        },
        '{
            10,  0,  9, 14,  6,  3, 15,  5,  1, 13, 12,  7, 11,  4,  2,  8,
            13,  7,  0,  9,  3,  4,  6, 10,  2,  8,  5, 14, 12, 11, 15,  1,
            13,  6,  4,  9,  8, 15,  3,  0, 11,  1,  2, 12,  5, 10, 14,  7,
             1, 10, 13,  0,  6,  9,  8,  7,  4, 15, 14,  3, 11,  5,  2, 12
        },
        '{
             7, 13, 14,  3,  0,  6,  9, 10,  1,  2,  8,  5, 11, 12,  4, 15,
            13,  8, 11,  5,  6, 15,  0,  3,  4,  7,  2, 12,  1, 10, 14,  9,
            10,  6,  9,  0, 12, 11,  7, 13, 15,  1,  3, 14,  5,  2,  8,  4,
             3, 15,  0,  6, 10,  1, 13,  8,  9,  4,  5, 11, 12,  7,  2, 14
        },
        '{
             2, 12,  4,  1,  7, 10, 11,  6,  8,  5,  3, 15, 13,  0, 14,  9,
            14, 11,  2, 12,  4,  7, 13,  1,  5,  0, 15, 10,  3,  9,  8,  6,
             4,  2,  1, 11, 10, 13,  7,  8, 15,  9, 12,  5,  6,  3,  0, 14,
            11,  8, 12,  7,  1, 14,  2, 13,  6, 15,  0,  9, 10,  4,  5,  3
        },
        '{
            12,  1, 10, 15,  9,  2,  6,  8,  0, 13,  3,  4, 14,  7,  5, 11,
            10, 15,  4,  2,  7, 12,  9,  5,  6,  1, 13, 14,  0, 11,  3,  8,
             9, 14, 15,  5,  2,  8, 12,  3,  7,  0,  4, 10,  1, 13, 11,  6,
             4,  3,  2, 12,  9,  5, 15, 10, 11, 14,  1,  7,  6,  0,  8, 13
        },
        '{
             4, 11,  2, 14, 15,  0,  8, 13,  3, 12,  9,  7,  5, 10,  6,  1,
            13,  0, 11,  7,  4,  9,  1, 10, 14,  3,  5, 12,  2, 15,  8,  6,
             1,  4, 11, 13, 12,  3,  7, 14, 10, 15,  6,  8,  0,  5,  9,  2,
             6, 11, 13,  8,  1,  4, 10,  7,  9,  5,  0, 15, 14,  2,  3, 12
        },
        '{
            13,  2,  8,  4,  6, 15, 11,  1, 10,  9,  3, 14,  5,  0, 12,  7,
             1, 15, 13,  8, 10,  3,  7,  4, 12,  5,  6, 11,  0, 14,  9,  2,
             7, 11,  4,  1,  9, 12, 14,  2,  0,  6, 10, 13, 15,  3,  5,  8,
             2,  1, 14,  7,  4, 10,  8, 13, 15, 12,  9,  0,  3,  5,  6, 11
        }
    };

    // box k takes the k-th 6-bit group counted from the most significant end.
    for (genvar k = 0; k < 8; k++) begin : g_box
        sbox_in_t grp;

        assign grp = mixed[47 - 6 * k -: 6];
        // the outer bits pick the row, the inner four the column.
        assign sub[31 - 4 * k -: 4] = sbox_tab[k][{grp[5], grp[0], grp[4:1]}];
    end

endmodule

/* hw/des_round.sv */
`timescale 1ns/1ns

module des_round (
    input  des_pkg::half_t   left,
    input  des_pkg::half_t   right,
    input  des_pkg::subkey_t subkey,
    output des_pkg::half_t   left_out,
    output des_pkg::half_t   right_out
);
    import des_pkg::*;

    subkey_t mixed;
    half_t   sub;

    assign mixed = expand(right) ^ subkey;

    des_sbox u_sbox (
        .mixed (mixed),
        .sub   (sub)
    );

    // the halves swap on every round, the final swap is undone in the block path.
    assign left_out  = right;
    assign right_out = left ^ p_perm(sub);

endmodule

/* hw/des_key_schedule.sv */
`timescale 1ns/1ns

module des_key_schedule #(
    parameter int ROUNDS_PER_CYCLE = 1
) (
    input  logic                                           ck,
    input  logic                                           rst,
    input  logic                                           key_capture,
    input  logic                                           decrypt,
    input  des_pkg::block_t                                key,
    input  des_pkg::round_idx_t                            step,
    output des_pkg::subkey_t [ROUNDS_PER_CYCLE-1:0]        subkeys
);
    import des_pkg::*;

    cd_t     cd_chain [des_rounds + 1];
    subkey_t sched [des_rounds];
    subkey_t ks [des_rounds];

    // both 28-bit halves rotate left by one or two places.
    function automatic cd_t rotate(cd_t cd, logic one);
        logic [27:0] c;
        logic [27:0] d;
        c = cd[55:28];
        d = cd[27:0];
        if (one) begin
            return {c[26:0], c[27], d[26:0], d[27]};
        end
        return {c[25:0], c[27:26], d[25:0], d[27:26]};
    endfunction

    assign cd_chain[0] = pc1(key);

    // the whole schedule unrolls into one combinational chain.
    for (genvar r = 0; r < des_rounds; r++) begin : g_sched
        assign cd_chain[r + 1] = rotate(cd_chain[r], shift_sched[r]);
        assign sched[r]        = pc2(cd_chain[r + 1]);
    end

    // decryption stores the schedule back to front so the round engine
    // always walks the file upwards.
    always_ff @(posedge ck) begin
        if (rst) begin
            for (int r = 0; r < des_rounds; r++) begin
                ks[r] <= '0;
            end
        end else if (key_capture) begin
            for (int r = 0; r < des_rounds; r++) begin
                ks[r] <= decrypt ? sched[des_rounds - 1 - r] : sched[r];
            end
        end
    end

    for (genvar j = 0; j < ROUNDS_PER_CYCLE; j++) begin : g_sel
        round_idx_t sel;

        assign sel        = round_idx_t'(int'(step) * ROUNDS_PER_CYCLE + j);
        assign subkeys[j] = ks[sel];
    end

endmodule

/* hw/des_block_path.sv */
`timescale 1ns/1ns

module des_block_path #(
    parameter int ROUNDS_PER_CYCLE = 1
) (
    input  logic                                    ck,
    input  logic                                    rst,
    input  logic                                    load_block,
    input  logic                                    round_en,
    input  des_pkg::block_t                         din,
    input  des_pkg::subkey_t [ROUNDS_PER_CYCLE-1:0] subkeys,
    output des_pkg::block_t                         dout
);
    import des_pkg::*;

    block_t lr;
    half_t  left_c [ROUNDS_PER_CYCLE + 1];
    half_t  right_c [ROUNDS_PER_CYCLE + 1];

    assign left_c[0]  = lr[63:32];
    assign right_c[0] = lr[31:0];

    // subkeys[0] belongs to the first round of the group.
    for (genvar g = 0; g < ROUNDS_PER_CYCLE; g++) begin : g_round
        des_round u_round (
            .left      (left_c[g]),
            .right     (right_c[g]),
            .subkey    (subkeys[g]),
            .left_out  (left_c[g + 1]),
            .right_out (right_c[g + 1])
        );
    end

    always_ff @(posedge ck) begin
        if (rst) begin
            lr <= '0;
        end else if (load_block) begin
            lr <= initial_perm(din);
        end else if (round_en) begin
            lr <= {left_c[ROUNDS_PER_CYCLE], right_c[ROUNDS_PER_CYCLE]};
        end
    end

    // output is R16 L16 through the final permutation.
    // it holds once the rounds stop.
    assign dout = final_perm({lr[31:0], lr[63:32]});

endmodule

/* hw/des_control.sv */
`timescale 1ns/1ns

module des_control #(
    parameter int ROUNDS_PER_CYCLE = 1
) (
    input  logic                ck,
    input  logic                rst,
    input  logic                start,
    input  logic                key_load,
    output logic                key_capture,
    output logic                load_block,
    output logic                round_en,
    output des_pkg::round_idx_t step,
    output logic                done,
    output logic                busy
);
    import des_pkg::*;

    localparam round_idx_t last_step = round_idx_t'(des_rounds / ROUNDS_PER_CYCLE - 1);

    des_state_t state;

    // strobes are only honoured while idle.
    assign key_capture = key_load && (state == st_idle);
    assign load_block  = start && (state == st_idle);

    assign done = (state == st_done);
    assign busy = (state != st_idle);

    // round_en comes from a flop, so the first run cycle only arms it
    // and the subkey mux starts from a registered step.
    always_ff @(posedge ck) begin
        if (rst) begin
            state    <= st_idle;
            step     <= '0;
            round_en <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        state <= st_run;
                        step  <= '0;
                    end
                end
                st_run: begin
                    if (!round_en) begin
                        round_en <= 1'b1;
                    end else if (step == last_step) begin
                        round_en <= 1'b0;
                        state    <= st_done;
                    end else begin
                        step <= step + 1'b1;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

/* hw/des_core.sv */
`timescale 1ns/1ns

module des_core #(
    parameter int ROUNDS_PER_CYCLE = 1
) (
    input  logic            ck,
    input  logic            rst,
    input  logic            key_load,
    input  logic            decrypt,
    input  logic            start,
    input  des_pkg::block_t key,
    input  des_pkg::block_t din,
    output des_pkg::block_t dout,
    output logic            done,
    output logic            busy
);
    import des_pkg::*;

    logic       key_capture;
    logic       load_block;
    logic       round_en;
    round_idx_t step;
    subkey_t [ROUNDS_PER_CYCLE-1:0] subkeys;

    des_control #(
        .ROUNDS_PER_CYCLE (ROUNDS_PER_CYCLE)
    ) u_control (
        .ck          (ck),
        .rst         (rst),
        .start       (start),
        .key_load    (key_load),
        .key_capture (key_capture),
        .load_block  (load_block),
        .round_en    (round_en),
        .step        (step),
        .done        (done),
        .busy        (busy)
    );

    des_key_schedule #(
        .ROUNDS_PER_CYCLE (ROUNDS_PER_CYCLE)
    ) u_key_schedule (
        .ck          (ck),
        .rst         (rst),
        .key_capture (key_capture),
        .decrypt     (decrypt),
        .key         (key),
        .step        (step),
        .subkeys     (subkeys)
    );

    des_block_path #(
        .ROUNDS_PER_CYCLE (ROUNDS_PER_CYCLE)
    ) u_block_path (
        .ck         (ck),
        .rst        (rst),
        .load_block (load_block),
        .round_en   (round_en),
        .din        (din),
        .subkeys    (subkeys),
        .dout       (dout)
    );

endmodule

/* testbench/des_vectors.svh */
`ifndef DES_VECTORS_SVH
`define DES_VECTORS_SVH

// columns are test name, key, plaintext and ciphertext, one row per index.
// the last row is the first one complemented, which DES maps to the complemented result.
localparam int n_vectors = 6;

string vec_name [n_vectors] = '{
    "fips_example", "fips_zero_out", "all_zero", "all_one", "now_is_t", "complement"
};

localparam logic [63:0] vec_key [n_vectors] = '{
    64'h1334_5779_9BBC_DFF1, 64'h0E32_9232_EA6D_0D73, 64'h0000_0000_0000_0000,
    64'hFFFF_FFFF_FFFF_FFFF, 64'h0123_4567_89AB_CDEF, 64'hECCB_A886_6443_200E
};

localparam logic [63:0] vec_pt [n_vectors] = '{
    64'h0123_4567_89AB_CDEF, 64'h8787_8787_8787_8787, 64'h0000_0000_0000_0000,
    64'hFFFF_FFFF_FFFF_FFFF, 64'h4E6F_7720_6973_2074, 64'hFEDC_BA98_7654_3210
};

localparam logic [63:0] vec_ct [n_vectors] = '{
    64'h85E8_1354_0F0A_B405, 64'h0000_0000_0000_0000, 64'h8CA6_4DE9_C1B1_23A7,
    64'h7359_B216_3E4E_DC58, 64'h3FA4_0E8A_984D_4815, 64'h7A17_ECAB_F0F5_4BFA
};

`endif

/* testbench/des_tb.sv */
`timescale 1ns/1ns

module des_tb;
    import des_pkg::*;

    localparam int rounds_per_cycle = 4;
    localparam int done_latency = 16 / rounds_per_cycle + 1;
    localparam int wait_limit = 40;
    localparam int random_trips = 8;

    logic   ck;
    logic   rst;
    logic   key_load;
    logic   decrypt;
    logic   start;
    block_t key;
    block_t din;
    block_t dout;
    logic   done;
    logic   busy;

    int     edge_count;
    int     mismatch_count;
    int     failure_count;
    integer seed;

    `include "des_vectors.svh"

    des_core #(
        .ROUNDS_PER_CYCLE (rounds_per_cycle)
    ) dut0 (
        .ck       (ck),
        .rst      (rst),
        .key_load (key_load),
        .decrypt  (decrypt),
        .start    (start),
        .key      (key),
        .din      (din),
        .dout     (dout),
        .done     (done),
        .busy     (busy)
    );

    initial begin
        ck = 1'b0;
        forever begin
            #50 ck = ~ck;
        end
    end

    // one rising edge, then the short delay after which inputs may change.
    task automatic tick();
        @(posedge ck);
        #5;
        edge_count++;
    endtask

    task automatic load_key(input block_t k, input logic dec);
        key      = k;
        decrypt  = dec;
        key_load = 1'b1;
        tick();
        key_load = 1'b0;
    endtask

    // edge_count is zero just after the edge that sampled start.
    task automatic start_block(input block_t blk, input string name);
        din   = blk;
        start = 1'b1;
        tick();
        start      = 1'b0;
        edge_count = 0;
        if (!busy) begin
            $display("%s: busy did not rise after start", name);
            failure_count++;
        end
    endtask

    // a second start and a key load with another key and direction, both while busy.
    task automatic issue_busy_strobes();
        block_t saved_key;
        logic   saved_dec;
        saved_key = key;
        saved_dec = decrypt;
        din       = ~din;
        key       = ~key;
        decrypt   = ~decrypt;
        start     = 1'b1;
        key_load  = 1'b1;
        tick();
        start    = 1'b0;
        key_load = 1'b0;
        key      = saved_key;
        decrypt  = saved_dec;
    endtask

    task automatic finish_block(input string name, output block_t result);
        result = '0;
        while (!done && edge_count < wait_limit) begin
            if (!busy) begin
                $display("%s: busy fell before done", name);
                failure_count++;
            end
            tick();
        end
        if (!done) begin
            $display("%s: timeout, done did not rise within %0d cycles", name, wait_limit);
            failure_count++;
        end else begin
            if (!busy) begin
                $display("%s: busy low while done is high", name);
                failure_count++;
            end
            if (edge_count != done_latency) begin
                $display("mismatch %s latency: expected %0d, actual %0d",
                         name, done_latency, edge_count);
                mismatch_count++;
            end
            result = dout;
            tick();
            if (done || busy) begin
                $display("%s: done or busy still high a cycle after done", name);
                failure_count++;
            end
        end
    endtask

    initial begin
        block_t result;
        block_t cipher;
        block_t plain;
        block_t rkey;
        seed           = 32'ha35b_941c;
        mismatch_count = 0;
        failure_count  = 0;
        edge_count     = 0;
        rst            = 1'b1;
        key_load       = 1'b0;
        decrypt        = 1'b0;
        start          = 1'b0;
        key            = '0;
        din            = '0;
        repeat (16) @(posedge ck);
        #5;
        rst = 1'b0;

        for (int i = 0; i < 8; i++) begin
            if (done || busy) begin
                $display("done or busy high after reset with no strobes applied");
                failure_count++;
            end
            tick();
        end

        for (int i = 0; i < n_vectors; i++) begin
            load_key(vec_key[i], 1'b0);
            start_block(vec_pt[i], vec_name[i]);
            finish_block(vec_name[i], result);
            if (result !== vec_ct[i]) begin
                $display("mismatch %s encrypt: expected %h, actual %h",
                         vec_name[i], vec_ct[i], result);
                mismatch_count++;
            end
        end

        for (int i = 0; i < n_vectors; i++) begin
            load_key(vec_key[i], 1'b1);
            start_block(vec_ct[i], vec_name[i]);
            finish_block(vec_name[i], result);
            if (result !== vec_pt[i]) begin
                $display("mismatch %s decrypt: expected %h, actual %h",
                         vec_name[i], vec_pt[i], result);
                mismatch_count++;
            end
        end

        load_key(vec_key[0], 1'b0);
        start_block(vec_pt[0], "busy_strobes");
        issue_busy_strobes();
        finish_block("busy_strobes", result);
        if (result !== vec_ct[0]) begin
            $display("mismatch busy_strobes: expected %h, actual %h", vec_ct[0], result);
            mismatch_count++;
        end
        // no new key load, so the original encryption key must still be in place.
        start_block(vec_pt[0], "key_kept");
        finish_block("key_kept", result);
        if (result !== vec_ct[0]) begin
            $display("mismatch key_kept: expected %h, actual %h", vec_ct[0], result);
            mismatch_count++;
        end

        for (int n = 0; n < random_trips; n++) begin
            rkey  = {$random(seed), $random(seed)};
            plain = {$random(seed), $random(seed)};
            load_key(rkey, 1'b0);
            start_block(plain, "random_encrypt");
            finish_block("random_encrypt", cipher);
            load_key(rkey, 1'b1);
            start_block(cipher, "random_decrypt");
            finish_block("random_decrypt", result);
            if (result !== plain) begin
                $display("mismatch random_trip_%0d: expected %h, actual %h", n, plain, result);
                mismatch_count++;
            end
        end

        $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+testbench
hw/des_pkg.sv
hw/des_sbox.sv
hw/des_round.sv
hw/des_key_schedule.sv
hw/des_block_path.sv
hw/des_control.sv
hw/des_core.sv
testbench/des_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing
LINTFLAGS = --lint-only --timing -Wall
TOP       = des_tb
FILELIST  = verilog.f
BUILD     = obj_dir
LOG       = sim.log
PASS_MSG  = >>> PASS
SOURCES   = $(wildcard hw/*.sv testbench/*.sv testbench/*.svh)

.PHONY: all build run lint clean

all: run

build: $(BUILD)/V$(TOP)

$(BUILD)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q -F -- '$(PASS_MSG)' $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD) $(LOG)
